//--- Makefile
# Verilator build and run of the trace unit testbench

VERILATOR ?= verilator
TOP       ?= tb_trace_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# the log decides the result, an assertion stop leaves no pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "all tests passed" $(LOG); then \
		echo "simulation ended without a pass line"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
verilog/trace_pkg.sv
verilog/trace_mem_if.sv
verilog/trace_ram.sv
verilog/trace_arbiter.sv
verilog/trace_recorder.sv
verilog/apb_trace_port.sv
verilog/trace_top.sv
testbench/trace_props.sv
testbench/tb_trace_top.sv

//--- testbench/tb_trace_top.sv
// trace unit testbench
`timescale 1ns/100ps
`default_nettype none

module tb_trace_top;
    import trace_pkg::*;

    localparam int TBL_LEN    = 14;
    localparam int FILL_N     = 40;
    localparam int TAIL_N     = 4;
    localparam int DRAIN_N    = 8;
    // pipeline cycles plus apb accesses with two per record and a few status reads
    localparam int RUN_CYCLES = 16 + TBL_LEN + FILL_N + 2 * TAIL_N + 4 * DRAIN_N;
    localparam int APB_N      = 2 * (TBL_LEN + TRACE_DEPTH + 2 * TAIL_N) + 12;
    localparam int MAX_CYCLES = RUN_CYCLES + 6 * APB_N + 200;

    ////////////////////////////////////////
    // stimulus table {fetch_valid, stall, flush, pc}
    ////////////////////////////////////////
    localparam logic [34:0] STIM [TBL_LEN] = '{
        {3'b100, 32'h0000_1000},
        {3'b100, 32'h0000_1004},
        {3'b100, 32'h0000_1008},
        // two stalls hold 1004 in decode and 1008 in fetch
        {3'b110, 32'h0000_100c},
        {3'b110, 32'h0000_100c},
        {3'b100, 32'h0000_100c},
        {3'b100, 32'h0000_1010},
        {3'b100, 32'h0000_1014},
        // flush kills 1010 and 1014
        {3'b101, 32'h0000_1018},
        {3'b100, 32'h0000_1020},
        {3'b100, 32'h0000_1024},
        // stall and flush together still empty the front end
        {3'b111, 32'h0000_1028},
        {3'b100, 32'h0000_1030},
        {3'b100, 32'h0000_1034}
    };

    logic      clk;
    logic      rst;
    logic      fetch_valid;
    pc_t       fetch_pc;
    logic      stall;
    logic      flush;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    // reference pipeline with slot 0 fetch .. 4 write-back
    logic        m_v   [5];
    pc_t         m_pc  [5];
    seq_t        m_seq [5];
    stall_cnt_t  m_sc  [5];
    int          m_ent [5];
    int          m_edge;
    seq_t        m_next;
    int          m_fill;
    int          m_drop;
    logic [63:0] exp_q [$];

    int        checks;
    int        errors;
    int        cycles;
    integer    seed;
    apb_data_t rdata;
    logic      err;
    // access cycles with pready low in the last transfer
    int        wait_states;

    trace_top dut_i (
        .clk(clk), .rst(rst),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .stall(stall), .flush(flush),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ends a run that stops making progress
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped at the cycle limit of %0d", MAX_CYCLES);
        $display("tests failed");
        $finish;
    end

    ////////////////////////////////////////
    // reference model called once per edge
    ////////////////////////////////////////
    task automatic model_edge(input logic fv, input pc_t pc, input logic st, input logic fl);
        logic [15:0] lat;
        // write-back occupant is recorded or dropped at this edge
        if (m_v[4]) begin
            lat = 16'(m_edge - m_ent[4]);
            if (m_fill < TRACE_DEPTH) begin
                exp_q.push_back({lat, m_sc[4], m_seq[4], m_pc[4]});
                m_fill++;
            end else if (m_drop < 255) begin
                m_drop++;
            end
        end
        m_edge++;
        for (int i = 4; i > 1; i--) begin
            m_v[i]   = m_v[i-1];
            m_pc[i]  = m_pc[i-1];
            m_seq[i] = m_seq[i-1];
            m_sc[i]  = m_sc[i-1];
            m_ent[i] = m_ent[i-1];
        end
        // execute takes a bubble when decode holds or is flushed
        m_v[2] = m_v[1] && !st && !fl;
        if (fl) begin
            m_v[1] = 1'b0;
            m_v[0] = 1'b0;
        end else if (!st) begin
            m_v[1]   = m_v[0];
            m_pc[1]  = m_pc[0];
            m_seq[1] = m_seq[0];
            m_sc[1]  = m_sc[0];
            m_ent[1] = m_ent[0];
            m_v[0]   = fv;
            m_pc[0]  = pc;
            m_seq[0] = m_next;
            m_sc[0]  = '0;
            m_ent[0] = m_edge;
            if (fv) begin
                m_next++;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (m_v[i] && m_sc[i] != 8'hff) begin
                    m_sc[i]++;
                end
            end
        end
    endtask

    // buffer and drop count go back to zero while the sequence keeps running
    task automatic model_clear();
        exp_q.delete();
        m_fill = 0;
        m_drop = 0;
    endtask

    task automatic drive_cycle(input logic fv, input pc_t pc, input logic st, input logic fl);
        @(posedge clk);
        #2;
        fetch_valid = fv;
        fetch_pc    = pc;
        stall       = st;
        flush       = fl;
        model_edge(fv, pc, st, fl);
    endtask

    // lets the last instruction reach memory
    task automatic idle_cycles();
        repeat (DRAIN_N) drive_cycle(1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic retire_stream(input int n, input logic rnd, input pc_t base);
        pc_t pc;
        for (int i = 0; i < n; i++) begin
            pc = rnd ? (pc_t'($random(seed)) & 32'hffff_fffc) : base + 32'(4 * i);
            drive_cycle(1'b1, pc, 1'b0, 1'b0);
        end
        idle_cycles();
    endtask

    ////////////////////////////////////////
    // apb master
    ////////////////////////////////////////
    task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t data, output logic resp_err);
        int waited;
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        waited  = 0;
        // pready is sampled mid cycle and the transfer ends at the next rise
        @(negedge clk);
        while (!pready && waited < 20) begin
            waited++;
            @(negedge clk);
        end
        if (!pready) begin
            $display("apb access to address 0x%0h got no pready within 20 cycles", addr);
            errors++;
        end
        wait_states = waited;
        data        = prdata;
        resp_err    = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic check_status(input int avail, input int drop);
        apb_data_t d;
        logic      e;
        apb_transfer(1'b0, REG_STATUS, '0, d, e);
        checks++;
        if (d !== {16'h0000, 8'(drop), 8'(avail)} || e !== 1'b0 || wait_states != 0) begin
            $display("ERROR %0t: status 0x%08h after %0d waits, expected avail %0d drop %0d",
                     $time, d, wait_states, avail, drop);
            errors++;
        end
    endtask

    // pops one record with the low word first
    task automatic check_record();
        apb_data_t   lo;
        apb_data_t   hi;
        logic        e_lo;
        logic        e_hi;
        int          lo_waits;
        logic [63:0] exp;
        exp = exp_q.pop_front();
        m_fill--;
        apb_transfer(1'b0, REG_DATA_LO, '0, lo, e_lo);
        lo_waits = wait_states;
        apb_transfer(1'b0, REG_DATA_HI, '0, hi, e_hi);
        checks++;
        if ({hi, lo} !== exp || e_lo !== 1'b0 || e_hi !== 1'b0) begin
            $display("ERROR %0t: record 0x%016h, expected pc 0x%08h seq %0d stalls %0d lat %0d",
                     $time, {hi, lo}, exp[31:0], exp[39:32], exp[47:40], exp[63:48]);
            errors++;
        end
        // data_lo ends two or three cycles into the access phase, data_hi at once
        checks++;
        if (lo_waits < 1 || lo_waits > 2 || wait_states != 0) begin
            $display("ERROR %0t: data_lo took %0d wait states and data_hi %0d",
                     $time, lo_waits, wait_states);
            errors++;
        end
    endtask

    task automatic drain_all();
        int n;
        n = exp_q.size();
        check_status(n, m_drop);
        repeat (n) check_record();
        check_status(0, m_drop);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        seed        = 95;
        checks      = 0;
        errors      = 0;
        wait_states = 0;
        m_edge      = 0;
        m_next      = '0;
        for (int i = 0; i < 5; i++) begin
            m_v[i] = 1'b0;
        end
        model_clear();
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        // a pop with nothing recorded gets an error response
        check_status(0, 0);
        apb_transfer(1'b0, REG_DATA_LO, '0, rdata, err);
        checks++;
        if (err !== 1'b1) begin
            $display("ERROR %0t: no pslverr on a data read of an empty buffer", $time);
            errors++;
        end

        // in-order stream with stalls and flushes
        for (int i = 0; i < TBL_LEN; i++) begin
            drive_cycle(STIM[i][34], STIM[i][31:0], STIM[i][33], STIM[i][32]);
        end
        idle_cycles();
        drain_all();

        // overfill keeps 32 and drops the rest
        retire_stream(FILL_N, 1'b1, '0);
        check_status(TRACE_DEPTH, FILL_N - TRACE_DEPTH);
        drain_all();

        // clear with records pending and then record again
        retire_stream(TAIL_N, 1'b0, 32'h0000_2000);
        check_status(TAIL_N, m_drop);
        apb_transfer(1'b1, REG_CONTROL, 32'h1, rdata, err);
        model_clear();
        check_status(0, 0);
        retire_stream(TAIL_N, 1'b0, 32'h0000_3000);
        drain_all();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/trace_props.sv
// trace unit handshake assertions
`timescale 1ns/100ps
`default_nettype none

module trace_props (
    input wire logic clk,
    input wire logic rst,
    input wire logic pready,
    input wire logic pslverr,
    // a is the apb requester, b the recorder
    input wire logic gnt_a,
    input wire logic gnt_b,
    input wire logic rd_gnt_a,
    input wire logic rvalid_a
);

    // error response only on the last access cycle
    pslverr_with_pready: assert property (
        @(posedge clk) disable iff (rst) pslverr |-> pready
    ) else $error("pslverr high while pready is low");

    // single port memory, one owner per cycle
    single_grant: assert property (
        @(posedge clk) disable iff (rst) !(gnt_a && gnt_b)
    ) else $error("both requesters granted in the same cycle");

    // read data one cycle after the grant, never otherwise
    rvalid_after_grant: assert property (
        @(posedge clk) disable iff (rst) rd_gnt_a |=> rvalid_a
    ) else $error("rvalid missing one cycle after a read grant");

    rvalid_needs_grant: assert property (
        @(posedge clk) disable iff (rst) rvalid_a |-> $past(rd_gnt_a)
    ) else $error("rvalid without a read grant in the cycle before");

endmodule

bind trace_arbiter trace_props arbiter_props_i (
    .clk(clk), .rst(rst), .pready(1'b0), .pslverr(1'b0),
    .gnt_a(apb_port.gnt), .gnt_b(rec_port.gnt),
    .rd_gnt_a(apb_port.gnt && !apb_port.we), .rvalid_a(apb_port.rvalid)
);

bind apb_trace_port trace_props apb_props_i (
    .clk(clk), .rst(rst), .pready(pready), .pslverr(pslverr),
    .gnt_a(mem.gnt), .gnt_b(1'b0),
    .rd_gnt_a(mem.gnt && !mem.we), .rvalid_a(mem.rvalid)
);

`default_nettype wire

//--- verilog/apb_trace_port.sv
// apb read-out port for trace records
`timescale 1ns/100ps
`default_nettype none

module apb_trace_port (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 psel,
    input  wire logic                 penable,
    input  wire logic                 pwrite,
    input  wire trace_pkg::apb_addr_t paddr,
    input  wire trace_pkg::apb_data_t pwdata,
    output      trace_pkg::apb_data_t prdata,
    output      logic                 pready,
    output      logic                 pslverr,
    input  wire trace_pkg::rec_cnt_t  wr_count,
    input  wire logic [7:0]           drop_count,
    output      trace_pkg::rec_cnt_t  rd_count,
    output      logic                 clear,
    trace_mem_if.requester            mem
);
    import trace_pkg::*;

    logic      setup;
    logic      access;
    logic      lo_read;
    logic      empty;
    rec_cnt_t  avail;

    // data_lo transfer progress
    logic      lo_req;
    logic      lo_done;
    logic      lo_err;

    // popped record halves
    apb_data_t lo_word;
    apb_data_t hi_word;

    assign setup   = psel && !penable;
    assign access  = psel && penable;
    assign lo_read = !pwrite && (paddr == REG_DATA_LO);
    assign avail   = wr_count - rd_count;
    assign empty   = (wr_count == rd_count);

    // data_lo waits for the record, all else is zero wait
    assign pready  = access && (!lo_read || lo_done || lo_err);
    assign pslverr = access && lo_read && lo_err;

    // write of control bit 0, one access cycle long
    assign clear = access && pwrite && (paddr == REG_CONTROL) && pwdata[0];

    ////////////////////////////////////////
    // record pop through the arbiter
    ////////////////////////////////////////
    assign mem.req   = lo_req;
    assign mem.we    = 1'b0;
    assign mem.addr  = rd_count[PTR_W-1:0];
    assign mem.wdata = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            lo_req   <= 1'b0;
            lo_done  <= 1'b0;
            lo_err   <= 1'b0;
            rd_count <= '0;
        end else begin
            // decide at setup, empty buffer gets an error
            if (setup && lo_read) begin
                lo_req <= !empty;
                lo_err <= empty;
            end else if (mem.gnt) begin
                lo_req <= 1'b0;
            end
            if (mem.rvalid) begin
                lo_done <= 1'b1;
            end else if (access && pready) begin
                lo_done <= 1'b0;
                lo_err  <= 1'b0;
            end
            if (clear) begin
                rd_count <= '0;
            end else if (mem.rvalid) begin
                rd_count <= rd_count + 1'b1;
            end
        end
    end

    // high word kept for the following data_hi read
    always_ff @(posedge clk) begin
        if (mem.rvalid) begin
            lo_word <= mem.rdata[31:0];
            hi_word <= mem.rdata[63:32];
        end
    end

    // read mux
    always_comb begin
        case (paddr)
            REG_STATUS:  prdata = {16'h0000, drop_count, avail[7:0]};
            REG_DATA_LO: prdata = lo_word;
            REG_DATA_HI: prdata = hi_word;
            default:     prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/trace_arbiter.sv
// trace memory arbiter
`timescale 1ns/100ps
`default_nettype none

module trace_arbiter (
    input  wire logic                  clk,
    input  wire logic                  rst,
    trace_mem_if.arbiter               rec_port,
    trace_mem_if.arbiter               apb_port,
    output      logic                  ram_en,
    output      logic                  ram_we,
    output      trace_pkg::rec_ptr_t   ram_addr,
    output      trace_pkg::trace_rec_t ram_wdata,
    input  wire trace_pkg::trace_rec_t ram_rdata
);

    // read owner for the returning data
    logic rd_rec;
    logic rd_apb;

    // recorder first, apb only when the recorder is idle
    assign rec_port.gnt = rec_port.req;
    assign apb_port.gnt = apb_port.req && !rec_port.req;

    ////////////////////////////////////////
    // ram port mux
    ////////////////////////////////////////
    assign ram_en    = rec_port.req || apb_port.req;
    assign ram_we    = rec_port.req ? rec_port.we    : apb_port.we;
    assign ram_addr  = rec_port.req ? rec_port.addr  : apb_port.addr;
    assign ram_wdata = rec_port.req ? rec_port.wdata : apb_port.wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_rec <= 1'b0;
            rd_apb <= 1'b0;
        end else begin
            // ram data lands one cycle after the grant
            rd_rec <= rec_port.gnt && !rec_port.we;
            rd_apb <= apb_port.gnt && !apb_port.we;
        end
    end

    // data goes back only to the port that asked
    assign rec_port.rvalid = rd_rec;
    assign rec_port.rdata  = rd_rec ? ram_rdata : '0;
    assign apb_port.rvalid = rd_apb;
    assign apb_port.rdata  = rd_apb ? ram_rdata : '0;

endmodule

`default_nettype wire

//--- verilog/trace_mem_if.sv
// trace memory requester link
`timescale 1ns/100ps
`default_nettype none

interface trace_mem_if;
    import trace_pkg::*;

    // request side, held until gnt
    logic       req;
    logic       we;
    rec_ptr_t   addr;
    trace_rec_t wdata;

    // grant side
    logic       gnt;
    // one cycle after a read grant
    logic       rvalid;
    trace_rec_t rdata;

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

`default_nettype wire

//--- verilog/trace_pkg.sv
// trace unit shared definitions
`default_nettype none

package trace_pkg;

    // ring buffer geometry
    localparam int TRACE_DEPTH = 32;
    localparam int PTR_W       = 5;

    ////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////
    typedef logic [31:0]      pc_t;
    typedef logic [7:0]       seq_t;
    typedef logic [15:0]      cycle_t;
    typedef logic [7:0]       stall_cnt_t;
    typedef logic [PTR_W-1:0] rec_ptr_t;
    typedef logic [15:0]      rec_cnt_t;

    // record layout, msb first: latency, stall count, sequence, pc
    typedef logic [63:0]      trace_rec_t;

    // apb side
    typedef logic [3:0]       apb_addr_t;
    typedef logic [31:0]      apb_data_t;

    // register map
    localparam apb_addr_t REG_STATUS  = 4'h0;
    localparam apb_addr_t REG_DATA_LO = 4'h4;
    localparam apb_addr_t REG_DATA_HI = 4'h8;
    localparam apb_addr_t REG_CONTROL = 4'hC;

endpackage

`default_nettype wire

//--- verilog/trace_ram.sv
// trace record memory
`timescale 1ns/100ps
`default_nettype none

module trace_ram (
    input  wire logic                  clk,
    input  wire logic                  ram_en,
    input  wire logic                  ram_we,
    input  wire trace_pkg::rec_ptr_t   ram_addr,
    input  wire trace_pkg::trace_rec_t ram_wdata,
    output      trace_pkg::trace_rec_t ram_rdata
);
    import trace_pkg::*;

    // one record per ring slot
    trace_rec_t mem [TRACE_DEPTH];

    // single port, write or registered read
    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_we) begin
                mem[ram_addr] <= ram_wdata;
            end else begin
                ram_rdata <= mem[ram_addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/trace_recorder.sv
// pipeline trace recorder
`timescale 1ns/100ps
`default_nettype none

module trace_recorder (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               fetch_valid,
    input  wire trace_pkg::pc_t     fetch_pc,
    input  wire logic               stall,
    input  wire logic               flush,
    input  wire logic               clear,
    input  wire trace_pkg::rec_cnt_t rd_count,
    output      trace_pkg::rec_cnt_t wr_count,
    output      logic [7:0]         drop_count,
    trace_mem_if.requester          mem
);
    import trace_pkg::*;

    // stage slots, index 0 fetch .. 4 write-back
    logic       st_v   [5];
    pc_t        st_pc  [5];
    seq_t       st_seq [5];
    cycle_t     st_ent [5];
    stall_cnt_t st_sc  [5];

    // free-running cycle count and next sequence number
    cycle_t     cyc;
    seq_t       seq_cnt;

    logic       entry;
    logic       full;
    rec_cnt_t   fill;
    cycle_t     latency;
    trace_rec_t rec;

    // stall counts stick at all ones
    function automatic stall_cnt_t sat_inc(input stall_cnt_t c);
        return (c == '1) ? c : stall_cnt_t'(c + 1'b1);
    endfunction

    // new instruction only when the front end moves
    assign entry = fetch_valid && !stall && !flush;

    ////////////////////////////////////////
    // stage occupancy
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 5; i++) begin
                st_v[i] <= 1'b0;
            end
            cyc     <= '0;
            seq_cnt <= '0;
        end else begin
            cyc <= cyc + 1'b1;
            // memory and write-back always advance
            st_v[4] <= st_v[3];
            st_v[3] <= st_v[2];
            // execute gets a bubble on stall or flush
            st_v[2] <= st_v[1] && !stall && !flush;
            if (flush) begin
                st_v[1] <= 1'b0;
                st_v[0] <= 1'b0;
            end else if (!stall) begin
                st_v[1] <= st_v[0];
                st_v[0] <= entry;
            end
            if (entry) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
        end
    end

    // slot payload follows the valid bits
    always_ff @(posedge clk) begin
        for (int i = 4; i > 1; i--) begin
            st_pc[i]  <= st_pc[i-1];
            st_seq[i] <= st_seq[i-1];
            st_ent[i] <= st_ent[i-1];
            st_sc[i]  <= st_sc[i-1];
        end
        if (!stall) begin
            st_pc[1]  <= st_pc[0];
            st_seq[1] <= st_seq[0];
            st_ent[1] <= st_ent[0];
            st_sc[1]  <= st_sc[0];
            // cycle count seen during the first fetch cycle
            st_pc[0]  <= fetch_pc;
            st_seq[0] <= seq_cnt;
            st_ent[0] <= cyc + 1'b1;
            st_sc[0]  <= '0;
        end else begin
            // held in fetch and decode
            if (st_v[0]) begin
                st_sc[0] <= sat_inc(st_sc[0]);
            end
            if (st_v[1]) begin
                st_sc[1] <= sat_inc(st_sc[1]);
            end
        end
    end

    ////////////////////////////////////////
    // record build and ring write
    ////////////////////////////////////////
    assign fill    = wr_count - rd_count;
    assign full    = (fill == rec_cnt_t'(TRACE_DEPTH));
    // cycles spent from fetch to write-back
    assign latency = cyc - st_ent[4];
    assign rec     = {latency, st_sc[4], st_seq[4], st_pc[4]};

    // single cycle request, the arbiter grants it at once
    assign mem.req   = st_v[4] && !full;
    assign mem.we    = 1'b1;
    assign mem.addr  = wr_count[PTR_W-1:0];
    assign mem.wdata = rec;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_count   <= '0;
            drop_count <= '0;
        end else begin
            if (mem.req && mem.gnt) begin
                wr_count <= wr_count + 1'b1;
            end
            // buffer full, count the loss
            if (st_v[4] && full && drop_count != 8'hff) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/trace_top.sv
// pipeline trace unit top level
`timescale 1ns/100ps
`default_nettype none

module trace_top (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 fetch_valid,
    input  wire trace_pkg::pc_t       fetch_pc,
    input  wire logic                 stall,
    input  wire logic                 flush,
    input  wire logic                 psel,
    input  wire logic                 penable,
    input  wire logic                 pwrite,
    input  wire trace_pkg::apb_addr_t paddr,
    input  wire trace_pkg::apb_data_t pwdata,
    output      trace_pkg::apb_data_t prdata,
    output      logic                 pready,
    output      logic                 pslverr
);
    import trace_pkg::*;

    // counts shared between the two memory users
    rec_cnt_t   wr_count;
    rec_cnt_t   rd_count;
    logic [7:0] drop_count;
    logic       clear;

    // ram side of the arbiter
    logic       ram_en;
    logic       ram_we;
    rec_ptr_t   ram_addr;
    trace_rec_t ram_wdata;
    trace_rec_t ram_rdata;

    trace_mem_if rec_mem ();
    trace_mem_if apb_mem ();

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////
    trace_recorder recorder_i (
        .clk(clk), .rst(rst),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
        .stall(stall), .flush(flush), .clear(clear),
        .rd_count(rd_count), .wr_count(wr_count),
        .drop_count(drop_count), .mem(rec_mem.requester)
    );

    trace_arbiter arbiter_i (
        .clk(clk), .rst(rst),
        .rec_port(rec_mem.arbiter), .apb_port(apb_mem.arbiter),
        .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
    );

    trace_ram ram_i (
        .clk(clk), .ram_en(ram_en), .ram_we(ram_we),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
    );

    apb_trace_port apb_i (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .wr_count(wr_count), .drop_count(drop_count),
        .rd_count(rd_count), .clear(clear), .mem(apb_mem.requester)
    );

endmodule

`default_nettype wire
